// ==== common/frame_pkg.sv ====
// byte frames up to 40 bytes including the xor checksum byte, through a 64 entry buffer
package frame_pkg;

    // byte lane width
    localparam int data_width = 8;

    // buffer address bits, 64 entries
    localparam int addr_width = 6;

    // longest legal frame, checksum byte counted
    localparam int max_frame_len = 40;

    // wide enough for any legal frame length
    localparam int len_width = 7;

    // one byte on the wire
    typedef struct packed {
        logic [data_width-1:0] data;
        logic                  last;
    } frame_beat_t;

    // checker output, bad only meaningful with last
    typedef struct packed {
        frame_beat_t beat;
        logic        bad;
    } tagged_beat_t;

    // per frame outcome, one flag at a time
    typedef struct packed {
        logic good_frame;
        logic bad_frame;
        logic overflow;
    } fifo_status_t;

    // length of a delivered frame in bytes
    typedef struct packed {
        logic [len_width-1:0] len;
    } frame_summary_t;

    // checker FSM
    typedef enum logic [1:0] {
        idle,
        in_frame,
        too_long
    } check_state_e;

endpackage

// ==== frame_check/frame_check.sv ====
// no input back-pressure; one-byte frames carry no payload and are tagged bad
`timescale 1ns/10ps

module frame_check import frame_pkg::*; (
    input  logic         input_clk,
    input  logic         async_rst,
    input  frame_beat_t  in_beat,
    input  logic         in_valid,
    output tagged_beat_t chk_beat,
    output logic         chk_valid
);

    check_state_e         state;
    // xor of the bytes seen so far in this frame
    logic [data_width-1:0] acc;
    // bytes seen so far without the current one
    logic [len_width-1:0]  cnt;
    logic [len_width-1:0]  cur_len;
    logic                  frame_bad;

    assign cur_len = cnt + 1'b1;

    // verdict if the current byte turns out to be the last one
    always_comb begin
        case (state)
            // a first byte that is also last leaves nothing to checksum
            idle:     frame_bad = 1'b1;
            in_frame: frame_bad = (in_beat.data != acc);
            too_long: frame_bad = 1'b1;
            default:  frame_bad = 1'b1;
        endcase
    end

    always_ff @(posedge input_clk or posedge async_rst) begin
        if (async_rst) begin
            state     <= idle;
            acc       <= '0;
            cnt       <= '0;
            chk_valid <= 1'b0;
        end else begin
            chk_valid <= in_valid;
            if (in_valid) begin
                case (state)
                    idle: begin
                        if (!in_beat.last) begin
                            acc   <= in_beat.data;
                            cnt   <= len_width'(1);
                            state <= in_frame;
                        end
                    end
                    in_frame: begin
                        if (in_beat.last) begin
                            state <= idle;
                        end else if (cur_len >= len_width'(max_frame_len)) begin
                            // another byte must follow, so the limit is already broken
                            state <= too_long;
                        end else begin
                            acc <= acc ^ in_beat.data;
                            cnt <= cur_len;
                        end
                    end
                    too_long: begin
                        // verdict already fixed until the last byte
                        if (in_beat.last) begin
                            state <= idle;
                        end
                    end
                    default: state <= idle;
                endcase
            end
        end
    end

    // payload trails the input by one cycle
    always_ff @(posedge input_clk) begin
        if (in_valid) begin
            chk_beat.beat <= in_beat;
            chk_beat.bad  <= in_beat.last & frame_bad;
        end
    end

    // a frame tagged good ends on the xor of its earlier bytes
    assert property (@(posedge input_clk) disable iff (async_rst)
        (chk_valid && chk_beat.beat.last && !chk_beat.bad) |-> (chk_beat.beat.data == acc))
        else $error("frame tagged good with a wrong checksum");

endmodule

// ==== frame_fifo/frame_fifo.sv ====
// input side always drops on full; a frame longer than the 64 entry buffer is always dropped
`timescale 1ns/10ps

module frame_fifo import frame_pkg::*; (
    input  logic         input_clk,
    input  logic         output_clk,
    input  logic         async_rst,
    input  tagged_beat_t chk_beat,
    input  logic         chk_valid,
    output frame_beat_t  fifo_beat,
    output logic         fifo_valid,
    input  logic         fifo_ready,
    output fifo_status_t fifo_status
);

    function automatic logic [addr_width:0] to_gray(input logic [addr_width:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    // storage, no reset
    frame_beat_t mem [2**addr_width];

    // per domain reset synchronizers
    logic [2:0] in_rst_sync;
    logic [2:0] out_rst_sync;
    logic       in_rst;
    logic       out_rst;

    // write side, committed and in-progress pointers
    logic [addr_width:0] wr_ptr;
    logic [addr_width:0] wr_ptr_cur;
    logic [addr_width:0] wr_ptr_next;
    logic [addr_width:0] wr_ptr_gray;
    logic [addr_width:0] wr_cur_gray;
    logic [addr_width:0] rd_gray_sync1;
    logic [addr_width:0] rd_gray_sync2;
    logic                drop_frame;
    logic                full;
    logic                mem_we;

    // read side
    logic [addr_width:0] rd_ptr;
    logic [addr_width:0] rd_ptr_next;
    logic [addr_width:0] rd_ptr_gray;
    logic [addr_width:0] wr_gray_sync1;
    logic [addr_width:0] wr_gray_sync2;
    logic                empty;
    logic                rd_en;

    // assert at once, release after three clocks
    always_ff @(posedge input_clk or posedge async_rst) begin
        if (async_rst) begin
            in_rst_sync <= '1;
        end else begin
            in_rst_sync <= {in_rst_sync[1:0], 1'b0};
        end
    end

    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            out_rst_sync <= '1;
        end else begin
            out_rst_sync <= {out_rst_sync[1:0], 1'b0};
        end
    end

    assign in_rst  = in_rst_sync[2];
    assign out_rst = out_rst_sync[2];

    // full is judged on the in-progress pointer,
    // so a frame can never run over unread data
    assign wr_cur_gray = to_gray(wr_ptr_cur);
    assign full = (wr_cur_gray == {~rd_gray_sync2[addr_width:addr_width-1],
                                   rd_gray_sync2[addr_width-2:0]});
    assign wr_ptr_next = wr_ptr_cur + 1'b1;
    assign mem_we      = chk_valid && !full && !drop_frame && !in_rst;

    always_ff @(posedge input_clk or posedge in_rst) begin
        if (in_rst) begin
            wr_ptr      <= '0;
            wr_ptr_cur  <= '0;
            wr_ptr_gray <= '0;
            drop_frame  <= 1'b0;
            fifo_status <= '0;
        end else begin
            fifo_status <= '0;
            if (chk_valid) begin
                if (full || drop_frame) begin
                    // no room, discard up to the end of the frame
                    drop_frame <= !chk_beat.beat.last;
                    if (chk_beat.beat.last) begin
                        wr_ptr_cur           <= wr_ptr;
                        fifo_status.overflow <= 1'b1;
                    end
                end else if (chk_beat.beat.last && chk_beat.bad) begin
                    // rewind to the last commit
                    wr_ptr_cur            <= wr_ptr;
                    fifo_status.bad_frame <= 1'b1;
                end else if (chk_beat.beat.last) begin
                    // publish the frame to the read side
                    wr_ptr_cur             <= wr_ptr_next;
                    wr_ptr                 <= wr_ptr_next;
                    wr_ptr_gray            <= to_gray(wr_ptr_next);
                    fifo_status.good_frame <= 1'b1;
                end else begin
                    wr_ptr_cur <= wr_ptr_next;
                end
            end
        end
    end

    always_ff @(posedge input_clk) begin
        if (mem_we) begin
            mem[wr_ptr_cur[addr_width-1:0]] <= chk_beat.beat;
        end
    end

    // read pointer into write domain
    always_ff @(posedge input_clk or posedge in_rst) begin
        if (in_rst) begin
            rd_gray_sync1 <= '0;
            rd_gray_sync2 <= '0;
        end else begin
            rd_gray_sync1 <= rd_ptr_gray;
            rd_gray_sync2 <= rd_gray_sync1;
        end
    end

    // committed pointer into read domain
    always_ff @(posedge output_clk or posedge out_rst) begin
        if (out_rst) begin
            wr_gray_sync1 <= '0;
            wr_gray_sync2 <= '0;
        end else begin
            wr_gray_sync1 <= wr_ptr_gray;
            wr_gray_sync2 <= wr_gray_sync1;
        end
    end

    assign empty       = (rd_ptr_gray == wr_gray_sync2);
    // refill the output register when it is free or being taken
    assign rd_en       = (fifo_ready || !fifo_valid) && !empty;
    assign rd_ptr_next = rd_ptr + 1'b1;

    always_ff @(posedge output_clk or posedge out_rst) begin
        if (out_rst) begin
            rd_ptr      <= '0;
            rd_ptr_gray <= '0;
            fifo_valid  <= 1'b0;
        end else begin
            if (fifo_ready || !fifo_valid) begin
                fifo_valid <= !empty;
            end
            if (rd_en) begin
                rd_ptr      <= rd_ptr_next;
                rd_ptr_gray <= to_gray(rd_ptr_next);
            end
        end
    end

    always_ff @(posedge output_clk) begin
        if (rd_en) begin
            fifo_beat <= mem[rd_ptr[addr_width-1:0]];
        end
    end

    // true occupancy against the live read pointer
    assert property (@(posedge input_clk) disable iff (in_rst)
        mem_we |-> ((addr_width+1)'(wr_ptr_cur - rd_ptr) < (2**addr_width)))
        else $error("buffer write while full");

    assert property (@(posedge output_clk) disable iff (out_rst)
        (fifo_valid && !fifo_ready) |=> (fifo_valid && $stable(fifo_beat)))
        else $error("fifo_beat changed while stalled");

    assert property (@(posedge input_clk) disable iff (in_rst)
        $onehot0(fifo_status))
        else $error("more than one status flag set");

endmodule

// ==== frame_stats/frame_stats.sv ====
// beats pass through without a register; lengths above 127 bytes would wrap
`timescale 1ns/10ps

module frame_stats import frame_pkg::*; (
    input  logic           output_clk,
    input  logic           async_rst,
    input  frame_beat_t    fifo_beat,
    input  logic           fifo_valid,
    output logic           fifo_ready,
    output frame_beat_t    out_beat,
    output logic           out_valid,
    input  logic           out_ready,
    output frame_summary_t summary,
    output logic           summary_valid
);

    // beats accepted so far in the current frame
    logic [len_width-1:0] len_cnt;
    logic                 accept;

    // straight through, the FIFO holds its output register under stall
    assign out_beat   = fifo_beat;
    assign out_valid  = fifo_valid;
    assign fifo_ready = out_ready;

    assign accept = fifo_valid && out_ready;

    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            len_cnt       <= '0;
            summary_valid <= 1'b0;
        end else begin
            summary_valid <= 1'b0;
            if (accept) begin
                if (fifo_beat.last) begin
                    // frame done, restart count
                    len_cnt       <= '0;
                    summary_valid <= 1'b1;
                end else begin
                    len_cnt <= len_cnt + 1'b1;
                end
            end
        end
    end

    // length includes the last beat
    always_ff @(posedge output_clk) begin
        if (accept && fifo_beat.last) begin
            summary.len <= len_cnt + 1'b1;
        end
    end

    // frames are at least two beats long upstream
    assert property (@(posedge output_clk) disable iff (async_rst)
        summary_valid |=> !summary_valid)
        else $error("summary_valid on consecutive cycles");

endmodule

// ==== design/frame_path_top.sv ====
// input side has no ready, frames that do not fit are dropped and flagged as overflow
`timescale 1ns/10ps

module frame_path_top import frame_pkg::*; (
    input  logic           input_clk,
    input  logic           output_clk,
    input  logic           async_rst,
    input  frame_beat_t    in_beat,
    input  logic           in_valid,
    output fifo_status_t   fifo_status,
    output frame_beat_t    out_beat,
    output logic           out_valid,
    input  logic           out_ready,
    output frame_summary_t summary,
    output logic           summary_valid
);

    // checker to FIFO, input_clk
    tagged_beat_t chk_beat;
    logic         chk_valid;

    // FIFO to stats, output_clk
    frame_beat_t  fifo_beat;
    logic         fifo_valid;
    logic         fifo_ready;

    frame_check frame_check_i (
        .input_clk (input_clk),
        .async_rst (async_rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .chk_beat  (chk_beat),
        .chk_valid (chk_valid)
    );

    frame_fifo frame_fifo_i (
        .input_clk   (input_clk),
        .output_clk  (output_clk),
        .async_rst   (async_rst),
        .chk_beat    (chk_beat),
        .chk_valid   (chk_valid),
        .fifo_beat   (fifo_beat),
        .fifo_valid  (fifo_valid),
        .fifo_ready  (fifo_ready),
        .fifo_status (fifo_status)
    );

    frame_stats frame_stats_i (
        .output_clk    (output_clk),
        .async_rst     (async_rst),
        .fifo_beat     (fifo_beat),
        .fifo_valid    (fifo_valid),
        .fifo_ready    (fifo_ready),
        .out_beat      (out_beat),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .summary       (summary),
        .summary_valid (summary_valid)
    );

endmodule

// ==== dv/frame_path_tb.sv ====
// run from the project root; stall flag 2 in the patterns file holds out_ready low
`timescale 1ns/10ps

module frame_path_tb import frame_pkg::*; ();

    logic           input_clk = 1'b0;
    logic           output_clk = 1'b0;
    logic           async_rst = 1'b1;
    frame_beat_t    in_beat = '0;
    logic           in_valid = 1'b0;
    fifo_status_t   fifo_status;
    frame_beat_t    out_beat;
    logic           out_valid;
    logic           out_ready = 1'b0;
    frame_summary_t summary;
    logic           summary_valid;

    integer seed = 32'h842c_1b9b;

    // frames sent and waiting for their status pulse
    logic [data_width-1:0] sent_bytes[$];
    int                    sent_lens[$];
    fifo_status_t          sent_exp[$];
    // beats of committed frames in commit order
    frame_beat_t           exp_beats[$];
    // beat counts of delivered frames awaiting their summary
    int                    counted_lens[$];
    logic [data_width-1:0] frame_buf[$];

    // 0 ready high, 1 random stalls, 2 held low
    logic [1:0]  ready_mode = 2'd0;
    // bytes committed since the held-low run began
    int          held_fill = 0;
    int          run_errors = 0;
    int          status_errors = 0;
    int          out_errors = 0;
    int          timeouts = 0;
    int          frames_sent = 0;
    int          good_seen = 0;
    int          bad_seen = 0;
    int          overflow_seen = 0;
    int          beat_count = 0;
    bit          held = 1'b0;
    frame_beat_t held_beat = '0;
    bit          timed_out = 1'b0;

    frame_path_top frame_path_top_i (
        .input_clk     (input_clk),
        .output_clk    (output_clk),
        .async_rst     (async_rst),
        .in_beat       (in_beat),
        .in_valid      (in_valid),
        .fifo_status   (fifo_status),
        .out_beat      (out_beat),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .summary       (summary),
        .summary_valid (summary_valid)
    );

    always #3 input_clk = ~input_clk;
    always #4 output_clk = ~output_clk;

    task automatic compare_status(input fifo_status_t exp, input fifo_status_t act,
                                  input string name, inout int count);
        if (act !== exp) begin
            count++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_beat(input frame_beat_t exp, input frame_beat_t act,
                                input string name, inout int count);
        if (act !== exp) begin
            count++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_summary(input frame_summary_t exp, input frame_summary_t act,
                                   input string name, inout int count);
        if (act !== exp) begin
            count++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    // value of an ascii hex digit or -1
    function automatic int hex_nibble(input byte c);
        int v;
        v = int'(c);
        if (v >= 48 && v <= 57) return v - 48;
        if (v >= 97 && v <= 102) return v - 87;
        if (v >= 65 && v <= 70) return v - 55;
        return -1;
    endfunction

    // first hex digit is the stall flag, then each digit pair is a byte
    task automatic parse_line(input string line, output int mode, output bit ok);
        int nib;
        int hi;
        bit have_mode;
        bit have_hi;
        frame_buf.delete();
        have_mode = 1'b0;
        have_hi   = 1'b0;
        hi        = 0;
        mode      = 0;
        for (int i = 0; i < line.len(); i++) begin
            // rest of the line is a comment
            if (line.getc(i) == "#") break;
            nib = hex_nibble(line.getc(i));
            if (nib >= 0) begin
                if (!have_mode) begin
                    mode      = nib;
                    have_mode = 1'b1;
                end else if (have_hi) begin
                    frame_buf.push_back(8'(hi * 16 + nib));
                    have_hi = 1'b0;
                end else begin
                    hi      = nib;
                    have_hi = 1'b1;
                end
            end
        end
        ok = have_mode && (frame_buf.size() > 0);
    endtask

    // a good frame has two bytes or more, fits the limit and ends on the xor of the rest
    function automatic bit frame_is_good();
        logic [data_width-1:0] x;
        int                    n;
        n = frame_buf.size();
        if (n < 2 || n > max_frame_len) return 1'b0;
        x = '0;
        for (int i = 0; i < n - 1; i++) begin
            x ^= frame_buf[i];
        end
        return frame_buf[n-1] == x;
    endfunction

    task automatic send_frame(input logic [1:0] mode);
        int           n;
        fifo_status_t exp;
        n   = frame_buf.size();
        exp = '0;
        // held frames pile up from an empty buffer until one no longer fits
        if (mode == 2'd2 && held_fill + n > 2**addr_width) begin
            exp.overflow = 1'b1;
        end else if (frame_is_good()) begin
            exp.good_frame = 1'b1;
            if (mode == 2'd2) held_fill += n;
        end else begin
            exp.bad_frame = 1'b1;
        end
        sent_lens.push_back(n);
        sent_exp.push_back(exp);
        foreach (frame_buf[i]) begin
            sent_bytes.push_back(frame_buf[i]);
        end
        for (int i = 0; i < n; i++) begin
            @(negedge input_clk);
            in_beat.data = frame_buf[i];
            in_beat.last = (i == n - 1);
            in_valid     = 1'b1;
        end
        @(negedge input_clk);
        in_valid = 1'b0;
        in_beat  = '0;
        // short idle gap between frames
        repeat (2) @(negedge input_clk);
        frames_sent++;
    endtask

    task automatic wait_drained(input int limit);
        int cycles;
        cycles = 0;
        while ((sent_lens.size() > 0 || exp_beats.size() > 0 || counted_lens.size() > 0)
               && cycles < limit) begin
            @(posedge output_clk);
            cycles++;
        end
        if (sent_lens.size() > 0 || exp_beats.size() > 0 || counted_lens.size() > 0) begin
            timeouts++;
            timed_out = 1'b1;
            $display("timeout: frames still outstanding after %0d output_clk cycles", limit);
        end
    endtask

    // pair each status pulse with the oldest frame sent
    always @(negedge input_clk) begin
        fifo_status_t exp;
        frame_beat_t  beat;
        int           n;
        if (!async_rst && fifo_status !== '0) begin
            if (sent_lens.size() == 0) begin
                status_errors++;
                $display("status pulse arrived with no frame outstanding");
            end else begin
                n   = sent_lens.pop_front();
                exp = sent_exp.pop_front();
                compare_status(exp, fifo_status, "fifo_status", status_errors);
                good_seen     += int'(fifo_status.good_frame);
                bad_seen      += int'(fifo_status.bad_frame);
                overflow_seen += int'(fifo_status.overflow);
                for (int i = 0; i < n; i++) begin
                    beat.data = sent_bytes.pop_front();
                    beat.last = (i == n - 1);
                    // only committed frames reach the output
                    if (exp.good_frame) begin
                        exp_beats.push_back(beat);
                    end
                end
            end
        end
    end

    // drive out_ready and check what the next posedge will take
    always @(negedge output_clk) begin
        bit             next_ready;
        frame_summary_t exp_sum;
        case (ready_mode)
            2'd1: next_ready = ($random(seed) & 1) != 0;
            2'd2: next_ready = 1'b0;
            default: next_ready = 1'b1;
        endcase
        if (!async_rst) begin
            if (held) begin
                if (!out_valid) begin
                    out_errors++;
                    $display("out_valid dropped while out_ready was low");
                end
                compare_beat(held_beat, out_beat, "out_beat stalled", out_errors);
            end
            if (out_valid && next_ready) begin
                if (exp_beats.size() == 0) begin
                    out_errors++;
                    $display("beat delivered with no committed frame pending");
                end else begin
                    compare_beat(exp_beats.pop_front(), out_beat, "out_beat", out_errors);
                end
                beat_count++;
                if (out_beat.last) begin
                    counted_lens.push_back(beat_count);
                    beat_count = 0;
                end
            end
            if (summary_valid) begin
                if (counted_lens.size() == 0) begin
                    out_errors++;
                    $display("summary pulse without a delivered frame");
                end else begin
                    exp_sum.len = len_width'(counted_lens.pop_front());
                    compare_summary(exp_sum, summary, "summary", out_errors);
                end
            end
            held      = out_valid && !next_ready;
            held_beat = out_beat;
        end
        out_ready = next_ready;
    end

    initial begin
        int    fd;
        int    mode;
        bit    ok;
        string line;
        repeat (10) @(posedge output_clk);
        @(negedge output_clk);
        async_rst = 1'b0;
        // FIFO input side leaves reset three input_clk cycles later
        repeat (5) @(negedge input_clk);
        fd = $fopen("dv/frame_path_patterns.txt", "r");
        if (fd == 0) begin
            run_errors++;
            $display("cannot open dv/frame_path_patterns.txt");
        end else begin
            while (!timed_out && $fgets(line, fd) > 0) begin
                parse_line(line, mode, ok);
                if (ok) begin
                    // a held-low run starts once the previous mode has drained the buffer
                    if (mode != 2) ready_mode = 2'(mode);
                    if (ready_mode != 2'd2) begin
                        wait_drained(4000);
                        held_fill = 0;
                    end
                    ready_mode = 2'(mode);
                    if (!timed_out) send_frame(2'(mode));
                end
            end
            $fclose(fd);
            ready_mode = 2'd0;
            if (!timed_out) wait_drained(4000);
            if (!timed_out && overflow_seen == 0) begin
                run_errors++;
                $display("no frame overflowed while out_ready was held low");
            end
        end
        $display("errors %0d (status %0d, output %0d, run %0d), timeouts %0d",
                 status_errors + out_errors + run_errors, status_errors, out_errors,
                 run_errors, timeouts);
        $display("frames %0d, good %0d, bad %0d, overflow %0d",
                 frames_sent, good_seen, bad_seen, overflow_seen);
        if (status_errors + out_errors + run_errors + timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/frame_path_patterns.txt ====
# stall flag: 0 out_ready high, 1 random stalls on out_ready, 2 out_ready held low
# then the frame bytes in hex, two digits each, spaces optional; last byte is the xor checksum
0 01020300
0 a55aff
0 10203041
0 deadbecd
0 00010203 04050607 08090a0b 0c0d0e0f 10111213 14151617 18191a1b 1c1d1e1f 20212223 24252627 00
0 00010203 04050607 08090a0b 0c0d0e0f 10111213 14151617 18191a1b 1c1d1e1f 20212223 24252627
1 11223344 55667788 99aabb00
1 0f0f0f01
1 c33cff
1 00010203 04050607 08090a0b 0c0d0e0f 10111213 14151617
1 80818283 84858687 88898a8b 8c8d8e8f
2 40414243 44454647 48494a4b 4c4d4e4f 50515253
2 60616263 64656667 68696a6b 6c6d6e6f 70717273
2 a0a1a2a3 a4a5a6a7 a8a9aaab acadaeaf b0b1b2b3
2 c0c1c2c3 c4c5c6c7 c8c9cacb cccdcecf d0d1d2d3
2 e0e1e2e3 e4e5e6e7 e8e9eaeb ecedeeef f0f1f2f3
0 12345670
1 aabbcc00
1 aabbccdd
0 7777

// ==== tb.f ====
common/frame_pkg.sv
frame_check/frame_check.sv
frame_fifo/frame_fifo.sv
frame_stats/frame_stats.sv
design/frame_path_top.sv
dv/frame_path_tb.sv

// ==== Makefile ====
# Verilator flow for the frame path testbench, run from the project root

TOP = frame_path_tb

.PHONY: all build run lint clean

all: run

build: obj_dir/V$(TOP)

obj_dir/V$(TOP): tb.f common/frame_pkg.sv frame_check/frame_check.sv \
		frame_fifo/frame_fifo.sv frame_stats/frame_stats.sv \
		design/frame_path_top.sv dv/frame_path_tb.sv
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "TB FAILED" sim.log; then echo "failure reported, see sim.log"; exit 1; fi
	@if ! grep -q "TB PASSED" sim.log; then echo "no pass line in sim.log"; exit 1; fi
	@echo "simulation passed"

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
